//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_mcu_board_io -f tb.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q -x "Result: PASSED" sim.log; then
    exit 0
else
    exit 1
fi

//--- source/board_io_pkg.sv
package board_io_pkg;

    //----------------------------------------------------------------------
    // microcontroller memory bus
    //----------------------------------------------------------------------

    // address and data word width
    localparam int w_bus    = 32;

    // one enable per byte lane
    localparam int w_ble    = w_bus / 8;

    // transfer type code
    localparam int w_trans  = 2;

    // no transfer in this cycle
    localparam logic [w_trans - 1:0] trans_idle = 2'b00;

    //----------------------------------------------------------------------
    // seven-segment display
    //----------------------------------------------------------------------

    // segments a to g, then the dot
    localparam int w_seg    = 8;

    // one hex digit
    localparam int w_nibble = 4;

    //----------------------------------------------------------------------
    // debug view selection
    //----------------------------------------------------------------------

    // which captured field goes to the display
    typedef enum logic [1:0]
    {
        view_addr  = 2'b00,
        view_rdata = 2'b01,
        view_wdata = 2'b10
    } bus_view_t;

endpackage

//--- source/bus_view_select.sv
`timescale 1ns/1ps

module bus_view_select
    import board_io_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,

    // exposed microcontroller bus
    input  logic                 mem_ready,
    input  logic                 mem_write,
    input  logic [w_trans - 1:0] mem_trans,
    input  logic [w_bus   - 1:0] mem_addr,
    input  logic [w_bus   - 1:0] mem_wdata,
    input  logic [w_bus   - 1:0] mem_rdata,

    // key[2:1] from the board
    input  logic [          1:0] view_key,

    output logic [w_bus   - 1:0] display_number
);

    //----------------------------------------------------------------------
    // transfer capture
    //----------------------------------------------------------------------

    logic               xfer_done;
    logic [w_bus - 1:0] addr_q;
    logic [w_bus - 1:0] wdata_q;
    logic [w_bus - 1:0] rdata_q;
    bus_view_t          view;

    // ready strobe on a real transfer
    assign xfer_done = mem_ready && (mem_trans != trans_idle);

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            addr_q  <= '0;
            wdata_q <= '0;
            rdata_q <= '0;
        end
        else if (xfer_done)
        begin
            // address on every transfer
            addr_q <= mem_addr;

            // data only for the matching direction
            if (mem_write)
                wdata_q <= mem_wdata;
            else
                rdata_q <= mem_rdata;
        end
    end

    //----------------------------------------------------------------------
    // field selection
    //----------------------------------------------------------------------

    // 11 falls back to the address
    always_comb
    begin
        case (view_key)
            2'b01:   view = view_rdata;
            2'b10:   view = view_wdata;
            default: view = view_addr;
        endcase
    end

    always_comb
    begin
        case (view)
            view_rdata: display_number = rdata_q;
            view_wdata: display_number = wdata_q;
            default:    display_number = addr_q;
        endcase
    end

endmodule

//--- source/mcu_board_io.sv
`timescale 1ns/1ps

module mcu_board_io
    import board_io_pkg::*;
#(
    parameter clk_mhz    = 50,
              w_digit    = 8,
              w_key      = 4,
              w_led      = 8,
              // 6000 cycles per MHz of clock
              nmi_period = clk_mhz * 6000,
              scan_div   = 4096
)
(
    input  logic                 clk,
    input  logic                 reset_n,

    // board keys
    input  logic [w_key   - 1:0] key,

    // microcontroller port registers
    input  logic [         15:0] port0_reg,
    input  logic [         15:0] port1_reg,
    input  logic [         15:0] port3_reg,

    // exposed microcontroller bus
    input  logic                 mem_ready,
    input  logic                 mem_write,
    input  logic [w_trans - 1:0] mem_trans,
    input  logic [w_bus   - 1:0] mem_addr,
    input  logic [w_bus   - 1:0] mem_wdata,
    input  logic [w_bus   - 1:0] mem_rdata,

    // board display and leds
    output logic [w_seg   - 1:0] abcdefgh,
    output logic [w_digit - 1:0] digit,
    output logic [w_led   - 1:0] led,

    // to the microcontroller
    output logic                 nmi_req
);

    //----------------------------------------------------------------------
    // internal wires
    //----------------------------------------------------------------------

    logic [w_bus   - 1:0] display_number;
    logic [w_seg   - 1:0] seg_debug;
    logic [w_digit - 1:0] digit_debug;

    //----------------------------------------------------------------------
    // interrupt tick
    //----------------------------------------------------------------------

    // enable on port 3 bit 0, manual request on key 3
    periodic_nmi
    #(
        .nmi_period (nmi_period)
    )
    i_periodic_nmi
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .irq_enable (port3_reg[0]),
        .key_nmi    (key[3]),
        .nmi_req    (nmi_req)
    );

    //----------------------------------------------------------------------
    // debug display path
    //----------------------------------------------------------------------

    bus_view_select i_bus_view_select
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .mem_ready      (mem_ready),
        .mem_write      (mem_write),
        .mem_trans      (mem_trans),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .view_key       (key[2:1]),
        .display_number (display_number)
    );

    seven_segment_display
    #(
        .w_digit  (w_digit),
        .scan_div (scan_div)
    )
    i_seven_segment_display
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .number   (display_number),
        .abcdefgh (seg_debug),
        .digit    (digit_debug)
    );

    //----------------------------------------------------------------------
    // panel outputs
    //----------------------------------------------------------------------

    // key 0 switches between software and debug display
    panel_output_mux
    #(
        .w_digit (w_digit),
        .w_led   (w_led)
    )
    i_panel_output_mux
    (
        .show_mode   (key[0]),
        .irq_enable  (port3_reg[0]),
        .seg_debug   (seg_debug),
        .digit_debug (digit_debug),
        .port0_reg   (port0_reg),
        .port1_reg   (port1_reg),
        .port3_reg   (port3_reg),
        .nmi_req     (nmi_req),
        .abcdefgh    (abcdefgh),
        .digit       (digit),
        .led         (led)
    );

endmodule

//--- source/panel_output_mux.sv
`timescale 1ns/1ps

module panel_output_mux
    import board_io_pkg::*;
#(
    parameter w_digit = 8,
              w_led   = 8
)
(
    input  logic                 show_mode,
    input  logic                 irq_enable,
    input  logic [w_seg   - 1:0] seg_debug,
    input  logic [w_digit - 1:0] digit_debug,
    input  logic [         15:0] port0_reg,
    input  logic [         15:0] port1_reg,
    input  logic [         15:0] port3_reg,
    input  logic                 nmi_req,
    output logic [w_seg   - 1:0] abcdefgh,
    output logic [w_digit - 1:0] digit,
    output logic [w_led   - 1:0] led
);

    //----------------------------------------------------------------------
    // software display path
    //----------------------------------------------------------------------

    logic [w_seg   - 1:0] seg_sw;
    logic [w_digit - 1:0] digit_sw;
    logic [          7:0] led_status;

    // port bit 7 is the dot, lands in the h position
    assign seg_sw   = {port0_reg[6:0], port0_reg[7]};

    // digit enables pass straight through
    assign digit_sw = port1_reg[w_digit - 1:0];

    // show mode picks the debug scan
    assign abcdefgh = show_mode ? seg_debug   : seg_sw;
    assign digit    = show_mode ? digit_debug : digit_sw;

    //----------------------------------------------------------------------
    // leds
    //----------------------------------------------------------------------

    // mode, interrupt, then the port 3 high byte
    assign led_status = {port3_reg[13:8], nmi_req, show_mode};

    assign led = w_led'(led_status);

endmodule

//--- source/periodic_nmi.sv
`timescale 1ns/1ps

module periodic_nmi
#(
    parameter nmi_period = 300000
)
(
    input  logic clk,
    input  logic reset_n,
    input  logic irq_enable,
    input  logic key_nmi,
    output logic nmi_req
);

    //----------------------------------------------------------------------
    // tick counter
    //----------------------------------------------------------------------

    // at least one bit even for a degenerate period
    localparam int w_cnt = (nmi_period > 1) ? $clog2(nmi_period) : 1;

    localparam logic [w_cnt - 1:0] cnt_last = w_cnt'(nmi_period - 1);

    logic [w_cnt - 1:0] tick_cnt;
    logic               tick_lim;
    logic               tick_lat;

    // last count of the period
    assign tick_lim = (tick_cnt == cnt_last);

    // free running, never held off by the enable
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            tick_cnt <= '0;
        else if (tick_lim)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    //----------------------------------------------------------------------
    // one-cycle tick latch
    //----------------------------------------------------------------------

    // high for exactly the cycle after the wrap
    // software gates it through the port bit
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            tick_lat <= 1'b0;
        else
            tick_lat <= irq_enable & tick_lim;
    end

    // held button overrides the enable
    assign nmi_req = tick_lat | key_nmi;

endmodule

//--- source/seven_segment_display.sv
`timescale 1ns/1ps

module seven_segment_display
    import board_io_pkg::*;
#(
    parameter w_digit  = 8,
              scan_div = 4096
)
(
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic [w_digit * w_nibble - 1:0] number,
    output logic [w_seg              - 1:0] abcdefgh,
    output logic [w_digit            - 1:0] digit
);

    //----------------------------------------------------------------------
    // widths
    //----------------------------------------------------------------------

    // keep both counters at least one bit wide
    localparam int w_pre = (scan_div > 1) ? $clog2(scan_div) : 1;
    localparam int w_idx = (w_digit  > 1) ? $clog2(w_digit)  : 1;

    localparam logic [w_pre - 1:0] pre_last = w_pre'(scan_div - 1);
    localparam logic [w_idx - 1:0] idx_last = w_idx'(w_digit  - 1);

    logic [w_pre    - 1:0] pre_cnt;
    logic [w_idx    - 1:0] digit_idx;
    logic [w_nibble - 1:0] nibble;

    //----------------------------------------------------------------------
    // hex glyphs
    //----------------------------------------------------------------------

    // active high, a in the msb, dot in the lsb and always off
    function automatic logic [w_seg - 1:0] hex_glyph(input logic [w_nibble - 1:0] value);
        case (value)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    //----------------------------------------------------------------------
    // scan timing
    //----------------------------------------------------------------------

    // prescaler sets how long each digit stays lit
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            pre_cnt <= '0;
        else if (pre_cnt == pre_last)
            pre_cnt <= '0;
        else
            pre_cnt <= pre_cnt + 1'b1;
    end

    // digit index, wraps after the last digit
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            digit_idx <= '0;
        else if (pre_cnt == pre_last)
        begin
            if (digit_idx == idx_last)
                digit_idx <= '0;
            else
                digit_idx <= digit_idx + 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // output registers
    //----------------------------------------------------------------------

    // digit 0 is the least significant nibble
    assign nibble = number[digit_idx * w_nibble +: w_nibble];

    // blank for one cycle out of reset, then digit 0
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            abcdefgh <= '0;
            digit    <= '0;
        end
        else
        begin
            abcdefgh <= hex_glyph(nibble);
            digit    <= w_digit'(1) << digit_idx;
        end
    end

endmodule

//--- tb.f
source/board_io_pkg.sv
source/periodic_nmi.sv
source/bus_view_select.sv
source/seven_segment_display.sv
source/panel_output_mux.sv
source/mcu_board_io.sv
test/tb_mcu_board_io.sv

//--- test/tb_mcu_board_io.sv
`timescale 1ns/1ps

module tb_mcu_board_io
    import board_io_pkg::*;
();

    localparam int w_digit    = 8;
    localparam int w_key      = 4;
    localparam int w_led      = 8;
    localparam int nmi_period = 50;
    localparam int scan_div   = 8;

    logic                 clk;
    logic                 reset_n;
    logic [w_key   - 1:0] key;
    logic [         15:0] port0_reg;
    logic [         15:0] port1_reg;
    logic [         15:0] port3_reg;
    logic                 mem_ready;
    logic                 mem_write;
    logic [w_trans - 1:0] mem_trans;
    logic [w_bus   - 1:0] mem_addr;
    logic [w_bus   - 1:0] mem_wdata;
    logic [w_bus   - 1:0] mem_rdata;
    logic [w_seg   - 1:0] abcdefgh;
    logic [w_digit - 1:0] digit;
    logic [w_led   - 1:0] led;
    logic                 nmi_req;

    // model of the captured fields and scan position
    logic [w_bus   - 1:0] m_addr;
    logic [w_bus   - 1:0] m_wdata;
    logic [w_bus   - 1:0] m_rdata;
    logic [w_bus   - 1:0] cur_num;
    logic [w_bus   - 1:0] prev_num;
    logic                 prev_enable;
    logic                 exp_nmi;
    int                   cyc;
    int                   exp_idx;

    integer seed = 20543;
    int     seg_errors;
    int     digit_errors;
    int     bit_errors;
    int     led_errors;
    int     timeout_errors;

    mcu_board_io
    #(
        .w_digit    (w_digit),
        .w_key      (w_key),
        .w_led      (w_led),
        .nmi_period (nmi_period),
        .scan_div   (scan_div)
    )
    uut
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .key       (key),
        .port0_reg (port0_reg),
        .port1_reg (port1_reg),
        .port3_reg (port3_reg),
        .mem_ready (mem_ready),
        .mem_write (mem_write),
        .mem_trans (mem_trans),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .abcdefgh  (abcdefgh),
        .digit     (digit),
        .led       (led),
        .nmi_req   (nmi_req)
    );

    initial clk = 1'b0;

    always #5 clk = ~clk;

    //----------------------------------------------------------------------
    // reference functions
    //----------------------------------------------------------------------

    // a in bit 7, dot in bit 0 and dark
    function automatic logic [w_seg - 1:0] hex_glyph(input logic [w_nibble - 1:0] value);
        logic [w_seg - 1:0] table_glyph [16];
        table_glyph = '{8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
                        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e};
        return table_glyph[value];
    endfunction

    // key[2:1] picks the field, 11 shows the address
    function automatic logic [w_bus - 1:0] expected_number(input logic [1:0] view_key,
        input logic [w_bus - 1:0] addr, input logic [w_bus - 1:0] wdata,
        input logic [w_bus - 1:0] rdata);
        bus_view_t view;
        view = (view_key == 2'b01) ? view_rdata :
               (view_key == 2'b10) ? view_wdata : view_addr;
        if (view == view_rdata)
            return rdata;
        else if (view == view_wdata)
            return wdata;
        return addr;
    endfunction

    // dot bit 7 moves to the bottom
    function automatic logic [w_seg - 1:0] port_segments(input logic [7:0] port_bits);
        return {port_bits[6:0], port_bits[7]};
    endfunction

    //----------------------------------------------------------------------
    // compare tasks
    //----------------------------------------------------------------------

    task automatic check_segments(input logic [w_seg - 1:0] got,
        input logic [w_seg - 1:0] exp, input string what);
        if (got !== exp)
        begin
            seg_errors++;
            $display("error %0t: %s abcdefgh %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_digit(input logic [w_digit - 1:0] got,
        input logic [w_digit - 1:0] exp, input string what);
        if (got !== exp)
        begin
            digit_errors++;
            $display("error %0t: %s digit %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            bit_errors++;
            $display("error %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_led(input logic [w_led - 1:0] got,
        input logic [w_led - 1:0] exp, input string what);
        if (got !== exp)
        begin
            led_errors++;
            $display("error %0t: %s %b, expected %b", $time, what, got, exp);
        end
    endtask

    //----------------------------------------------------------------------
    // compare at mid cycle where outputs are settled
    //----------------------------------------------------------------------

    always @(negedge clk)
    begin
        if (!reset_n)
        begin
            m_addr      = '0;
            m_wdata     = '0;
            m_rdata     = '0;
            prev_num    = '0;
            prev_enable = 1'b0;
            cyc         = 0;
        end
        else
        begin
            cur_num = expected_number(key[2:1], m_addr, m_wdata, m_rdata);

            // tick lands every nmi_period cycles after release
            exp_nmi = key[3] | (prev_enable & (cyc != 0) & (cyc % nmi_period == 0));
            check_bit(nmi_req, exp_nmi, "nmi_req");
            check_led(led, {port3_reg[13:8], exp_nmi, key[0]}, "led");

            if (key[0])
            begin
                // first cycle out of reset is blank
                if (cyc == 0)
                begin
                    check_digit(digit, '0, "blank");
                    check_segments(abcdefgh, '0, "blank");
                end
                else
                begin
                    exp_idx = ((cyc - 1) / scan_div) % w_digit;
                    check_digit(digit, w_digit'(1) << exp_idx, "debug scan");
                    check_segments(abcdefgh,
                        hex_glyph(prev_num[exp_idx * w_nibble +: w_nibble]), "debug scan");
                end
            end
            else
            begin
                check_segments(abcdefgh, port_segments(port0_reg[7:0]), "software");
                check_digit(digit, port1_reg[w_digit - 1:0], "software");
            end

            // advance the model to the next cycle
            prev_num    = cur_num;
            prev_enable = port3_reg[0];
            if (mem_ready && (mem_trans != trans_idle))
            begin
                m_addr = mem_addr;
                if (mem_write)
                    m_wdata = mem_wdata;
                else
                    m_rdata = mem_rdata;
            end
            cyc++;
        end
    end

    //----------------------------------------------------------------------
    // stimulus
    //----------------------------------------------------------------------

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic bus_transfer(input logic write, input logic ready,
        input logic [w_trans - 1:0] trans);
        next_cycle();
        mem_ready = ready;
        mem_write = write;
        mem_trans = trans;
        mem_addr  = $random(seed);
        mem_wdata = $random(seed);
        mem_rdata = $random(seed);
    endtask

    task automatic bus_idle();
        next_cycle();
        mem_ready = 1'b0;
        mem_trans = trans_idle;
    endtask

    // completing transfers of random direction
    task automatic random_transfers(input int count);
        logic [w_trans - 1:0] trans;
        logic                 write;
        int                   i;
        for (i = 0; i < count; i++)
        begin
            trans = w_trans'($random(seed));
            if (trans == trans_idle)
                trans = 2'b10;
            write = 1'($random(seed));
            bus_transfer(write, 1'b1, trans);
        end
        bus_idle();
    endtask

    task automatic set_view(input logic [1:0] view_key);
        next_cycle();
        key[2:1] = view_key;
    endtask

    // every index within one full scan
    task automatic wait_all_digits(input string what);
        logic [w_digit - 1:0] seen;
        int                   n;
        int                   b;
        seen = '0;
        for (n = 0; n < w_digit * scan_div + 2 && seen != '1; n++)
        begin
            @(negedge clk);
            if ($onehot(digit))
                for (b = 0; b < w_digit; b++)
                    if (digit[b])
                        seen[b] = 1'b1;
        end
        if (seen != '1)
        begin
            timeout_errors++;
            $display("timeout waiting for all digits to scan in %s, seen %b", what, seen);
        end
    endtask

    task automatic wait_nmi_pulses(input int count);
        int k;
        int n;
        for (k = 0; k < count; k++)
        begin
            n = 0;
            @(negedge clk);
            while (nmi_req !== 1'b1 && n < nmi_period + 2)
            begin
                @(negedge clk);
                n++;
            end
            if (nmi_req !== 1'b1)
            begin
                timeout_errors++;
                $display("timeout waiting for periodic interrupt pulse %0d", k);
                return;
            end
        end
    endtask

    initial
    begin
        reset_n   = 1'b0;
        key       = 4'b0001;
        port0_reg = '0;
        port1_reg = '0;
        port3_reg = 16'h0001;
        mem_ready = 1'b0;
        mem_write = 1'b0;
        mem_trans = trans_idle;
        mem_addr  = '0;
        mem_wdata = '0;
        mem_rdata = '0;
        repeat (4) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // address view after random traffic
        random_transfers(12);
        wait_all_digits("address view");

        // writes touch only the write data
        set_view(2'b01);
        repeat (4) bus_transfer(1'b1, 1'b1, 2'b10);
        bus_idle();
        wait_all_digits("read view after writes");
        set_view(2'b10);
        wait_all_digits("write view after writes");

        // reads touch only the read data
        repeat (4) bus_transfer(1'b0, 1'b1, 2'b11);
        bus_idle();
        wait_all_digits("write view after reads");
        set_view(2'b01);
        wait_all_digits("read view after reads");

        // no ready or idle type, nothing captured
        bus_transfer(1'b1, 1'b0, 2'b10);
        bus_transfer(1'b0, 1'b0, 2'b01);
        bus_transfer(1'b1, 1'b1, trans_idle);
        bus_transfer(1'b0, 1'b1, trans_idle);
        bus_idle();
        wait_all_digits("read view after ignored transfers");
        set_view(2'b11);
        wait_all_digits("address view after ignored transfers");

        // software display and led bits
        next_cycle();
        key[0] = 1'b0;
        repeat (20)
        begin
            next_cycle();
            port0_reg = 16'($random(seed));
            port1_reg = 16'($random(seed));
            port3_reg = 16'($random(seed)) | 16'h0001;
        end
        next_cycle();
        key[0] = 1'b1;

        // periodic tick, then disabled
        wait_nmi_pulses(3);
        next_cycle();
        port3_reg[0] = 1'b0;
        repeat (3 * nmi_period) next_cycle();

        // held key overrides the enable, low and then high
        key[3] = 1'b1;
        repeat (10) next_cycle();
        port3_reg[0] = 1'b1;
        repeat (10) next_cycle();
        key[3] = 1'b0;
        wait_nmi_pulses(2);
        repeat (4) next_cycle();

        $display("errors: segments %0d digit %0d nmi %0d led %0d timeout %0d",
            seg_errors, digit_errors, bit_errors, led_errors, timeout_errors);
        if (seg_errors + digit_errors + bit_errors + led_errors + timeout_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
